//--- common/stackPkg.sv
`default_nettype none

package stackPkg;

    // memory address width, the top level passes this down as ADDR_WIDTH
    localparam int DEFAULT_ADDR_WIDTH = 7;   // 128 entries

    // width of one stack entry
    localparam int DATA_WIDTH = 8;

    // one stack or switch value
    typedef logic [DATA_WIDTH-1:0] dataWord;

    // the stack grows downward from the last address
    // an empty stack has the pointer at all ones for the chosen address width
    // pop writes zero back into the freed entry

endpackage

`default_nettype wire

//--- common/commandPkg.sv
`default_nettype none

package commandPkg;

    // button nibble ordered {left, right, down, up}
    typedef logic [3:0] buttonCode;

    // decoded commands, one strobe per press
    typedef enum logic [2:0] {
        cmdNone,
        cmdPush,     // switches onto the stack
        cmdPop,      // drop the top entry
        cmdAdd,      // second + top
        cmdSub,      // second - top
        cmdTop,      // display back to the top entry
        cmdIncAddr,  // display address + 1
        cmdDecAddr   // display address - 1
    } calcCommand;

    // button patterns
    localparam buttonCode BTN_RELEASED = 4'b0000;  // rearms the decoder
    localparam buttonCode BTN_CLEAR    = 4'b1010;  // left + down, level sensitive
    localparam buttonCode BTN_PUSH     = 4'b0001;
    localparam buttonCode BTN_POP      = 4'b0010;
    localparam buttonCode BTN_ADD      = 4'b0101;
    localparam buttonCode BTN_SUB      = 4'b0110;
    localparam buttonCode BTN_TOP      = 4'b1001;
    localparam buttonCode BTN_DEC_ADDR = 4'b1110;
    localparam buttonCode BTN_INC_ADDR = 4'b1101;

    // stack sequencer states
    typedef enum logic [3:0] {
        stIdle,
        stPushWrite,      // switch value goes into memory
        stReadFirst,      // top address on the bus
        stCaptureFirst,   // top value arrives
        stClearFirst,     // zero the old top, pointer moves up
        stReadSecond,     // new top address on the bus
        stCaptureSecond,  // second value arrives, result computed
        stWriteResult,    // result written over the new top
        stPopWrite        // zero written into the popped entry
    } seqState;

endpackage

`default_nettype wire

//--- design/commandDecoder.sv
`default_nettype none

module commandDecoder
    import commandPkg::*;
(
    input  wire buttonCode  buttons,
    input  wire logic       CLK,
    input  wire logic       rst,
    output logic            cmdStrobe,
    output calcCommand      cmd,
    output logic            clearLevel
);

    buttonCode  buttonsReg;   // sampled nibble
    calcCommand decoded;      // match on the sampled nibble
    logic       armed;        // cleared after a command fires

    // pattern match, clear is not a strobed command
    always_comb
    begin
        case (buttonsReg)
            BTN_PUSH:     decoded = cmdPush;
            BTN_POP:      decoded = cmdPop;
            BTN_ADD:      decoded = cmdAdd;
            BTN_SUB:      decoded = cmdSub;
            BTN_TOP:      decoded = cmdTop;
            BTN_INC_ADDR: decoded = cmdIncAddr;
            BTN_DEC_ADDR: decoded = cmdDecAddr;
            default:      decoded = cmdNone;   // released, clear and unknown codes
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            buttonsReg <= BTN_RELEASED;
            armed      <= 1'b1;
            cmdStrobe  <= 1'b0;
            cmd        <= cmdNone;
            clearLevel <= 1'b0;
        end
        else
        begin
            buttonsReg <= buttons;
            cmdStrobe  <= 1'b0;                         // one cycle only
            cmd        <= cmdNone;
            clearLevel <= (buttonsReg == BTN_CLEAR);    // held as long as the pattern is

            if (buttonsReg == BTN_RELEASED)
            begin
                armed <= 1'b1;                          // all buttons up
            end
            else if (armed && (decoded != cmdNone))
            begin
                cmdStrobe <= 1'b1;
                cmd       <= decoded;
                armed     <= 1'b0;                      // wait for release
            end
        end
    end

endmodule

`default_nettype wire

//--- stack/stackMemory.sv
`default_nettype none

module stackMemory
    import stackPkg::*;
#(
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
) (
    input  wire logic                  CLK,
    input  wire logic                  cs,
    input  wire logic                  we,
    input  wire logic [ADDR_WIDTH-1:0] addr,
    input  wire dataWord               wrData,
    output dataWord                    rdData,
    input  wire logic [ADDR_WIDTH-1:0] dispAddr,
    output dataWord                    dispRdData
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    dataWord mem [DEPTH];

    // stack port, read returns the old word on a write cycle
    always_ff @(posedge CLK)
    begin
        if (cs)
        begin
            if (we)
                mem[addr] <= wrData;
            rdData <= mem[addr];   // holds while cs is low
        end
    end

    // display port reads every cycle
    always_ff @(posedge CLK)
    begin
        dispRdData <= mem[dispAddr];
    end

endmodule

`default_nettype wire

//--- stack/stackSequencer.sv
`default_nettype none

module stackSequencer
    import stackPkg::*;
    import commandPkg::*;
#(
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
) (
    input  wire logic                  CLK,
    input  wire logic                  rst,
    input  wire logic                  cmdStrobe,
    input  wire calcCommand            cmd,
    input  wire logic                  clearLevel,
    input  wire dataWord               switches,
    input  wire dataWord               memRdData,
    output logic                       memCs,
    output logic                       memWe,
    output logic [ADDR_WIDTH-1:0]      memAddr,
    output dataWord                    memWrData,
    output logic [ADDR_WIDTH-1:0]      stackPtr,
    output logic                       refreshTop,
    output logic                       stackEmpty
);

    // pointer values that gate pop, add and sub
    localparam logic [ADDR_WIDTH-1:0] EMPTY_ADDR    = '1;
    localparam logic [ADDR_WIDTH-1:0] ONE_LEFT_ADDR = EMPTY_ADDR - 1'b1;

    seqState               state;
    dataWord               operand;     // old top, first operand
    logic                  opIsSub;     // add or subtract in flight
    logic [ADDR_WIDTH-1:0] topAddr;     // current top entry
    logic                  canCombine;  // at least two entries

    assign topAddr    = stackPtr + 1'b1;   // SPR points at the next free slot
    assign stackEmpty = (stackPtr == EMPTY_ADDR);
    assign canCombine = (stackPtr != EMPTY_ADDR) && (stackPtr != ONE_LEFT_ADDR);

    always_ff @(posedge CLK)
    begin
        if (rst || clearLevel)
        begin
            // clear aborts whatever is running
            state      <= stIdle;
            stackPtr   <= EMPTY_ADDR;
            memCs      <= 1'b0;
            memWe      <= 1'b0;
            refreshTop <= 1'b0;
        end
        else
        begin
            memCs      <= 1'b0;   // memory strobes last one cycle unless a state asks again
            memWe      <= 1'b0;
            refreshTop <= 1'b0;

            case (state)
                stIdle:
                begin
                    if (cmdStrobe)
                    begin
                        case (cmd)
                            cmdPush:
                            begin
                                memCs      <= 1'b1;
                                memWe      <= 1'b1;
                                memAddr    <= stackPtr;     // next free slot
                                memWrData  <= switches;
                                stackPtr   <= stackPtr - 1'b1;
                                refreshTop <= 1'b1;         // same cycle as the write
                                state      <= stPushWrite;
                            end
                            cmdPop:
                            begin
                                if (!stackEmpty)            // nothing to drop otherwise
                                begin
                                    memCs      <= 1'b1;
                                    memWe      <= 1'b1;
                                    memAddr    <= topAddr;
                                    memWrData  <= '0;       // freed entry reads back as zero
                                    stackPtr   <= topAddr;
                                    refreshTop <= 1'b1;
                                    state      <= stPopWrite;
                                end
                            end
                            cmdAdd, cmdSub:
                            begin
                                if (canCombine)
                                begin
                                    memCs   <= 1'b1;        // read the top
                                    memAddr <= topAddr;
                                    opIsSub <= (cmd == cmdSub);
                                    state   <= stReadFirst;
                                end
                            end
                            default:
                            begin
                                state <= stIdle;            // display commands, tracker's job
                            end
                        endcase
                    end
                end

                stPushWrite, stPopWrite:
                begin
                    state <= stIdle;   // write lands at this edge
                end

                stReadFirst:
                begin
                    state <= stCaptureFirst;   // registered read, data next cycle
                end

                stCaptureFirst:
                begin
                    operand   <= memRdData;
                    memCs     <= 1'b1;
                    memWe     <= 1'b1;
                    memAddr   <= topAddr;      // zero the old top
                    memWrData <= '0;
                    stackPtr  <= topAddr;
                    state     <= stClearFirst;
                end

                stClearFirst:
                begin
                    memCs   <= 1'b1;
                    memAddr <= topAddr;        // pointer already moved, this is the second entry
                    state   <= stReadSecond;
                end

                stReadSecond:
                begin
                    state <= stCaptureSecond;
                end

                stCaptureSecond:
                begin
                    memCs <= 1'b1;
                    memWe <= 1'b1;             // memAddr still holds the new top
                    if (opIsSub)
                        memWrData <= memRdData - operand;   // second minus top, borrow dropped
                    else
                        memWrData <= memRdData + operand;   // carry dropped
                    state <= stWriteResult;
                end

                stWriteResult:
                begin
                    refreshTop <= 1'b1;        // result is in memory now
                    state      <= stIdle;
                end

                default:
                begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/displayTracker.sv
`default_nettype none

module displayTracker
    import stackPkg::*;
    import commandPkg::*;
#(
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
) (
    input  wire logic                  CLK,
    input  wire logic                  rst,
    input  wire logic                  cmdStrobe,
    input  wire calcCommand            cmd,
    input  wire logic                  clearLevel,
    input  wire logic                  refreshTop,
    input  wire logic [ADDR_WIDTH-1:0] stackPtr,
    input  wire dataWord               dispRdData,
    output logic [ADDR_WIDTH-1:0]      dispAddr,
    output dataWord                    displayValue
);

    logic [1:0] pending;      // cycles until the read port shows the new address
    logic       loadTop;
    logic       stepUp;
    logic       stepDown;

    assign loadTop  = refreshTop || (cmdStrobe && (cmd == cmdTop));
    assign stepUp   = cmdStrobe && (cmd == cmdIncAddr);
    assign stepDown = cmdStrobe && (cmd == cmdDecAddr);

    always_ff @(posedge CLK)
    begin
        if (rst || clearLevel)
        begin
            dispAddr     <= '0;
            displayValue <= '0;
            pending      <= 2'd0;
        end
        else
        begin
            if (loadTop)
            begin
                dispAddr <= stackPtr + 1'b1;   // top entry
                pending  <= 2'd2;
            end
            else if (stepUp)
            begin
                dispAddr <= dispAddr + 1'b1;   // wraps at the ends
                pending  <= 2'd2;
            end
            else if (stepDown)
            begin
                dispAddr <= dispAddr - 1'b1;
                pending  <= 2'd2;
            end
            else if (pending != 2'd0)
            begin
                pending <= pending - 2'd1;
            end

            // one edge for the address register, one for the registered read
            if (pending == 2'd1)
                displayValue <= dispRdData;
        end
    end

endmodule

`default_nettype wire

//--- design/stackCalculator.sv
`default_nettype none

module stackCalculator
    import stackPkg::*;
    import commandPkg::*;
#(
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
) (
    input  wire logic      CLK,
    input  wire logic      rst,
    input  wire buttonCode buttons,
    input  wire dataWord   switches,
    output logic [7:0]     leds,
    output dataWord        displayValue
);

    logic                  cmdStrobe;
    calcCommand            cmd;
    logic                  clearLevel;
    logic                  memCs;
    logic                  memWe;
    logic [ADDR_WIDTH-1:0] memAddr;
    dataWord               memWrData;
    dataWord               memRdData;
    logic [ADDR_WIDTH-1:0] stackPtr;
    logic                  refreshTop;
    logic                  stackEmpty;
    logic [ADDR_WIDTH-1:0] dispAddr;
    dataWord               dispRdData;

    // empty flag on the top LED, display address below it
    assign leds = {stackEmpty, 7'(dispAddr)};

    commandDecoder i_commandDecoder (
        .CLK        (CLK),
        .rst        (rst),
        .buttons    (buttons),
        .cmdStrobe  (cmdStrobe),
        .cmd        (cmd),
        .clearLevel (clearLevel)
    );

    stackSequencer #(.ADDR_WIDTH(ADDR_WIDTH)) i_stackSequencer (
        .CLK        (CLK),
        .rst        (rst),
        .cmdStrobe  (cmdStrobe),
        .cmd        (cmd),
        .clearLevel (clearLevel),
        .switches   (switches),
        .memRdData  (memRdData),
        .memCs      (memCs),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWrData  (memWrData),
        .stackPtr   (stackPtr),
        .refreshTop (refreshTop),
        .stackEmpty (stackEmpty)
    );

    stackMemory #(.ADDR_WIDTH(ADDR_WIDTH)) i_stackMemory (
        .CLK        (CLK),
        .cs         (memCs),
        .we         (memWe),
        .addr       (memAddr),
        .wrData     (memWrData),
        .rdData     (memRdData),
        .dispAddr   (dispAddr),      // own port, no sharing with the sequencer
        .dispRdData (dispRdData)
    );

    displayTracker #(.ADDR_WIDTH(ADDR_WIDTH)) i_displayTracker (
        .CLK          (CLK),
        .rst          (rst),
        .cmdStrobe    (cmdStrobe),
        .cmd          (cmd),
        .clearLevel   (clearLevel),
        .refreshTop   (refreshTop),
        .stackPtr     (stackPtr),
        .dispRdData   (dispRdData),
        .dispAddr     (dispAddr),
        .displayValue (displayValue)
    );

endmodule

`default_nettype wire

//--- sim/stimulusTable.svh
`ifndef STIMULUS_TABLE_SVH
`define STIMULUS_TABLE_SVH

// columns: button code pressed, switch value, expected displayValue,
// expected display address, expected empty flag (last four filled by the stack model)

localparam logic [3:0] PRESS_RELEASED = 4'b0000;
localparam logic [3:0] PRESS_CLEAR    = 4'b1010;  // left + down
localparam logic [3:0] PRESS_PUSH     = 4'b0001;
localparam logic [3:0] PRESS_POP      = 4'b0010;
localparam logic [3:0] PRESS_ADD      = 4'b0101;
localparam logic [3:0] PRESS_SUB      = 4'b0110;
localparam logic [3:0] PRESS_TOP      = 4'b1001;
localparam logic [3:0] PRESS_DEC      = 4'b1110;
localparam logic [3:0] PRESS_INC      = 4'b1101;
localparam logic [3:0] PRESS_UNKNOWN  = 4'b1111;  // matches no command

localparam int ROW_COUNT = 30;

localparam logic [3:0] ROW_BUTTONS [ROW_COUNT] = '{
    PRESS_RELEASED,  // 0  reset values only
    PRESS_POP,       // 1  empty stack, ignored
    PRESS_ADD,       // 2  empty stack, ignored
    PRESS_PUSH,      // 3  first entry at 7F
    PRESS_ADD,       // 4  one entry, ignored
    PRESS_PUSH,      // 5
    PRESS_PUSH,      // 6  top at 7D
    PRESS_ADD,       // 7  sum lands at 7E
    PRESS_PUSH,      // 8
    PRESS_SUB,       // 9  second minus top
    PRESS_PUSH,      // 10
    PRESS_PUSH,      // 11
    PRESS_POP,       // 12 back to 7D
    PRESS_INC,       // 13 stored entry below the top
    PRESS_DEC,       // 14
    PRESS_DEC,       // 15 freed slot, reads zero
    PRESS_TOP,       // 16 back to SPR+1
    PRESS_UNKNOWN,   // 17 nothing happens
    PRESS_PUSH,      // 18
    PRESS_SUB,       // 19
    PRESS_ADD,       // 20
    PRESS_ADD,       // 21 last two entries, one left at 7F
    PRESS_CLEAR,     // 22 empty again
    PRESS_POP,       // 23 ignored after clear
    PRESS_PUSH,      // 24 starts again at 7F
    PRESS_PUSH,      // 25
    PRESS_SUB,       // 26
    PRESS_TOP,       // 27
    PRESS_DEC,       // 28 zeroed by the sub
    PRESS_INC        // 29
};

logic [7:0] rowSwitches [ROW_COUNT];  // random byte on push rows, zero elsewhere
logic [7:0] rowValue    [ROW_COUNT];
logic [6:0] rowAddr     [ROW_COUNT];
logic       rowEmpty    [ROW_COUNT];

`endif

//--- sim/tbStackCalculator.sv
`default_nettype none

module tbStackCalculator;

    localparam int ADDR_BITS      = 7;
    localparam int PERIOD         = 20;
    localparam int RESET_CYCLES   = 4;
    localparam int PRESS_CYCLES   = 2;
    localparam int RELEASE_CYCLES = 14;
    localparam int DRIVE_DELAY    = 2;      // after the rising edge
    localparam logic [6:0] EMPTY_PTR = 7'h7F;

    logic       CLK;
    logic       rst;
    logic [3:0] buttons;
    logic [7:0] switches;
    logic [7:0] leds;
    logic [7:0] displayValue;

    `include "stimulusTable.svh"

    // every row takes press plus release cycles, margin covers reset
    localparam int CYCLE_LIMIT = ROW_COUNT * (PRESS_CYCLES + RELEASE_CYCLES) + 50;

    // reference stack, grows down from 7F like the hardware
    logic [7:0]  modelMem [128];
    logic [6:0]  modelSp;
    logic [6:0]  modelAddr;     // display address register
    logic [7:0]  modelValue;    // display value register
    logic [31:0] lfsr;
    int          cycleCount;

    stackCalculator #(.ADDR_WIDTH(ADDR_BITS)) i_dut (
        .CLK          (CLK),
        .rst          (rst),
        .buttons      (buttons),
        .switches     (switches),
        .leds         (leds),
        .displayValue (displayValue)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

    // Fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawByte(output logic [7:0] value);
        int b;
        value = 8'h00;
        for (b = 0; b < 8; b++)
        begin
            lfsr  = lfsrStep(lfsr);          // one step per bit
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic showEntry(input logic [6:0] addr);
        modelAddr  = addr;
        modelValue = modelMem[addr];
    endtask

    // one decoded press applied to the reference stack
    task automatic modelPress(input logic [3:0] code, input logic [7:0] sw);
        logic [7:0] topValue;
        logic [6:0] entries;
        entries = EMPTY_PTR - modelSp;
        case (code)
            PRESS_PUSH:
            begin
                modelMem[modelSp] = sw;
                modelSp = modelSp - 7'd1;
                showEntry(modelSp + 7'd1);
            end
            PRESS_POP:
            begin
                if (entries != 7'd0)         // empty stack is left alone
                begin
                    modelSp = modelSp + 7'd1;
                    modelMem[modelSp] = 8'h00;
                    showEntry(modelSp + 7'd1);
                end
            end
            PRESS_ADD, PRESS_SUB:
            begin
                if (entries >= 7'd2)
                begin
                    modelSp = modelSp + 7'd1;
                    topValue = modelMem[modelSp];
                    modelMem[modelSp] = 8'h00;
                    if (code == PRESS_SUB)
                        modelMem[modelSp + 7'd1] = modelMem[modelSp + 7'd1] - topValue;
                    else
                        modelMem[modelSp + 7'd1] = modelMem[modelSp + 7'd1] + topValue;
                    showEntry(modelSp + 7'd1);
                end
            end
            PRESS_TOP: showEntry(modelSp + 7'd1);
            PRESS_INC: showEntry(modelAddr + 7'd1);
            PRESS_DEC: showEntry(modelAddr - 7'd1);
            PRESS_CLEAR:
            begin
                modelSp    = EMPTY_PTR;        // memory keeps its contents
                modelAddr  = 7'd0;
                modelValue = 8'h00;
            end
            default:
            begin
                modelAddr = modelAddr;         // released or unknown code
            end
        endcase
    endtask

    // switch values and expected columns of the table
    task automatic buildTable();
        logic [7:0] sw;
        int         r;
        lfsr       = 32'h469eb1f2;
        modelSp    = EMPTY_PTR;
        modelAddr  = 7'd0;
        modelValue = 8'h00;
        for (r = 0; r < ROW_COUNT; r++)
        begin
            sw = 8'h00;
            if (ROW_BUTTONS[r] == PRESS_PUSH)
                drawByte(sw);
            modelPress(ROW_BUTTONS[r], sw);
            rowSwitches[r] = sw;
            rowValue[r]    = modelValue;
            rowAddr[r]     = modelAddr;
            rowEmpty[r]    = (modelSp == EMPTY_PTR);
        end
    endtask

    task automatic compareValue(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    initial
    begin
        int r;
        rst       = 1'b1;
        buttons   = PRESS_RELEASED;
        switches  = 8'h00;
        buildTable();

        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (r = 0; r < ROW_COUNT; r++)
        begin
            buttons  = ROW_BUTTONS[r];
            switches = rowSwitches[r];        // held until the next row
            repeat (PRESS_CYCLES) @(posedge CLK);
            #DRIVE_DELAY;
            buttons = PRESS_RELEASED;         // rearms the decoder
            repeat (RELEASE_CYCLES) @(posedge CLK);
            #DRIVE_DELAY;
            compareValue($sformatf("row %0d leds[7]", r), {7'd0, leds[7]}, {7'd0, rowEmpty[r]});
            compareValue($sformatf("row %0d leds[6:0]", r), {1'b0, leds[6:0]}, {1'b0, rowAddr[r]});
            compareValue($sformatf("row %0d displayValue", r), displayValue, rowValue[r]);
        end

        $display("Verification passed");
        $finish;
    end

    // watchdog
    initial
    begin
        cycleCount = 0;
        forever
        begin
            @(posedge CLK);
            cycleCount++;
            if (cycleCount >= CYCLE_LIMIT)
            begin
                $display("timeout: the table did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Verification failed");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
common/stackPkg.sv
common/commandPkg.sv
design/commandDecoder.sv
stack/stackMemory.sv
stack/stackSequencer.sv
design/displayTracker.sv
design/stackCalculator.sv
sim/tbStackCalculator.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tbStackCalculator -o simStackCalculator &&
./obj_dir/simStackCalculator | tee /dev/stderr | grep -qx "Verification passed" &&
echo "run.sh: simulation PASS" ||
{ echo "run.sh: simulation FAIL"; exit 1; }
